//--- Makefile
TOP := cacheTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -qx '>>> PASS' sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log

//--- dv/cacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTb;
  import cachePkg::*;

  localparam int ClkPeriod = 8;
  localparam int ResetCycles = 16;
  localparam int NumEntries = 18;
  // worst miss: Compare, four beats each behind a gap, Reread, Compare, some slack
  localparam int MaxMissCycles = 16;
  localparam int WatchdogNs = (ResetCycles + NumEntries * MaxMissCycles) * ClkPeriod;

  // {expected miss, address}; A, B and C share set 2, E and F share set 63
  localparam logic [32:0] StimTable [NumEntries] = '{
    {1'b1, 32'h0001_0040},  // A cold miss
    {1'b0, 32'h0001_0048},
    {1'b0, 32'h0001_0058},
    {1'b0, 32'h0001_0053},  // byte offset ignored
    {1'b1, 32'h0002_0108},  // D cold miss, set 8
    {1'b0, 32'h0002_0118},
    {1'b1, 32'h8000_3ff8},  // E cold miss
    {1'b1, 32'h0001_0840},  // B takes the second way of set 2
    {1'b0, 32'h0001_0850},
    {1'b0, 32'h0001_0048},  // A touched last
    {1'b1, 32'h0001_1040},  // C evicts B
    {1'b0, 32'h0001_0058},
    {1'b1, 32'h0001_0848},  // B back, evicts C
    {1'b1, 32'h0001_1050},  // C back, evicts A
    {1'b0, 32'h0001_0858},
    {1'b0, 32'h0002_0105},
    {1'b1, 32'hffff_ffe8},  // F second way of set 63
    {1'b0, 32'h8000_3fe0}
  };

  logic clk;
  logic rst_n;
  addr_t addr;
  logic valid;
  logic addrOk;
  logic dataOk;
  word_t rdData;
  logic cacheRdValid;
  addr_t cacheAddr;
  logic rdValid;
  logic rdLast;
  word_t memData;

  int errCount = 0;
  int checkCount = 0;
  int respCount = 0;
  // table positions accepted and still waiting for dataOk_o
  int pending[$];
  logic missSeen = 1'b0;

  clkGen #(.Period(ClkPeriod), .ResetCycles(ResetCycles)) i_clkGen (
    .clk(clk),
    .rst_n(rst_n)
  );

  cacheTop i_cacheTop (
    .clk(clk),
    .rst_n(rst_n),
    .addr_i(addr),
    .valid_i(valid),
    .addrOk_o(addrOk),
    .dataOk_o(dataOk),
    .rdData_o(rdData),
    .cacheRdValid_o(cacheRdValid),
    .cacheAddr_o(cacheAddr),
    .rdValid_i(rdValid),
    .rdLast_i(rdLast),
    .rdData_i(memData)
  );

  memResponder #(.Seed(32'hb24b)) i_memResponder (
    .clk(clk),
    .cacheRdValid_i(cacheRdValid),
    .cacheAddr_i(cacheAddr),
    .rdValid_o(rdValid),
    .rdLast_o(rdLast),
    .rdData_o(memData)
  );

  // memory word: own address low, address xor 5a5a5a5a high
  function automatic word_t patternWord(input addr_t a);
    addr_t w;
    w = {a[31:3], 3'b000};
    return {w ^ 32'h5a5a_5a5a, w};
  endfunction

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp,
                         input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERROR @%0t ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // responses return in request order, a refill belongs to the oldest request
  always @(negedge clk) begin : collect
    int idx;
    addr_t lineAddr;
    if (rst_n && dataOk) begin
      if (pending.size() == 0) begin
        errCount++;
        $display("ERROR @%0t ns: dataOk_o with no request outstanding", $time);
      end else begin
        idx = pending.pop_front();
        checkEq(rdData, patternWord(StimTable[idx][31:0]),
                $sformatf("entry %0d rdData_o", idx));
        checkEq(64'(missSeen), 64'(StimTable[idx][32]), $sformatf("entry %0d miss", idx));
        respCount++;
      end
      missSeen = 1'b0;
    end
    if (rst_n && cacheRdValid) begin
      missSeen = 1'b1;
      if (pending.size() == 0) begin
        errCount++;
        $display("ERROR @%0t ns: cacheRdValid_o with no request outstanding", $time);
      end else begin
        lineAddr = {StimTable[pending[0]][31:5], 5'b00000};
        checkEq(64'(cacheAddr), 64'(lineAddr), "cacheAddr_o during refill");
      end
    end
  end

  initial begin : stimulus
    logic prevHit;
    prevHit = 1'b0;
    valid = 1'b0;
    addr = '0;
    @(posedge rst_n);
    @(negedge clk);
    for (int i = 0; i < NumEntries; i++) begin
      valid = 1'b1;
      addr = StimTable[i][31:0];
      // a hit in Compare takes the next request at once
      if (prevHit) begin
        checkEq(64'(addrOk), 64'(1'b1), $sformatf("entry %0d addrOk_o behind a hit", i));
      end
      while (!addrOk) begin
        @(negedge clk);
      end
      pending.push_back(i);
      @(negedge clk);
      prevHit = !StimTable[i][32];
    end
    valid = 1'b0;
    while (respCount < NumEntries) begin
      @(negedge clk);
    end
    repeat (4) begin
      @(negedge clk);
    end
    $display("checks %0d, errors %0d, responses %0d of %0d",
             checkCount, errCount, respCount, NumEntries);
    if (errCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("watchdog expired at %0t ns: dataOk_o missing, %0d of %0d responses arrived",
             $time, respCount, NumEntries);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
  parameter int Period = 8,
  parameter int ResetCycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(Period / 2);
      clk = ~clk;
    end
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/memResponder.sv
`timescale 1ns/1ps
`default_nettype none

module memResponder #(
  parameter logic [31:0] Seed = 32'hb24b
) (
  input wire clk,
  input wire cacheRdValid_i,
  input wire cachePkg::addr_t cacheAddr_i,
  output logic rdValid_o,
  output logic rdLast_o,
  output cachePkg::word_t rdData_o
);
  import cachePkg::*;

  logic [31:0] lfsr = Seed;
  int beat = 0;
  logic bitTaken = 1'b0;
  logic gapBit;
  addr_t beatAddr;

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  initial begin
    rdValid_o = 1'b0;
    rdLast_o = 1'b0;
    rdData_o = '0;
  end

  always @(negedge clk) begin
    rdValid_o = 1'b0;
    rdLast_o = 1'b0;
    if (!cacheRdValid_i) begin
      beat = 0;
      bitTaken = 1'b0;
    end else if (beat < BeatsPerLine) begin
      // one lfsr bit per beat, a set bit holds the beat back a cycle
      gapBit = 1'b0;
      if (!bitTaken) begin
        gapBit = lfsr[0];
        lfsr = lfsrStep(lfsr);
        bitTaken = 1'b1;
      end
      if (!gapBit) begin
        beatAddr = cacheAddr_i + addr_t'(beat * 8);
        rdValid_o = 1'b1;
        rdLast_o = (beat == BeatsPerLine - 1);
        rdData_o = {beatAddr ^ 32'h5a5a_5a5a, beatAddr};
        beat++;
        bitTaken = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cacheArrayIf.sv
`timescale 1ns/1ps
`default_nettype none

interface cacheArrayIf #(
  parameter int NumSets = 64
);
  import cachePkg::*;

  localparam int IdxW = $clog2(NumSets);
  // tag grows when there are fewer sets
  localparam int TagBits = $bits(tag_t) + $bits(index_t) - IdxW;

  // lookup side
  logic lookupEn;
  logic [IdxW-1:0] lookupIndex;
  wordSel_t lookupWord;
  logic [TagBits-1:0] lookupTag;

  // refill side
  logic fillEn;
  logic [IdxW-1:0] fillIndex;
  wordSel_t fillWord;
  word_t fillData;
  logic fillDone;

  // array results, valid the cycle after lookupEn
  logic hit;
  logic hitWay;
  logic victimWay;
  word_t rdWay0;
  word_t rdWay1;

  modport ctrl (
    output lookupEn, lookupIndex, lookupWord, lookupTag,
    output fillEn, fillIndex, fillWord, fillData, fillDone,
    input hit, hitWay, victimWay, rdWay0, rdWay1
  );

  modport tags (
    input lookupEn, lookupIndex, lookupTag, fillDone, fillIndex,
    output hit, hitWay, victimWay
  );

  modport data (
    input lookupEn, lookupIndex, lookupWord,
    input fillEn, fillIndex, fillWord, fillData, victimWay,
    output rdWay0, rdWay1
  );

endinterface

`default_nettype wire

//--- logic/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl #(
  parameter int NumSets = 64
) (
  input wire clk,
  input wire rst_n,

  // pipeline side
  input wire cachePkg::addr_t addr_i,
  input wire valid_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output cachePkg::word_t rdData_o,

  // memory side
  output logic cacheRdValid_o,
  output cachePkg::addr_t cacheAddr_o,
  input wire rdValid_i,
  input wire rdLast_i,
  input wire cachePkg::word_t rdData_i,

  cacheArrayIf.ctrl arr
);
  import cachePkg::*;

  localparam int IdxW = $clog2(NumSets);
  localparam int TagBits = $bits(tag_t) + $bits(index_t) - IdxW;

  ctrlState_t state;
  ctrlState_t nextState;

  addr_t reqAddr;
  addr_t lookupAddr;
  wordSel_t beatCnt;
  logic accept;

  // new request taken in Idle, or behind a hit in Compare
  assign addrOk_o = (state == Idle) || (state == Compare && arr.hit);
  assign accept = valid_i && addrOk_o;

  assign dataOk_o = (state == Compare) && arr.hit;
  assign rdData_o = arr.hitWay ? arr.rdWay1 : arr.rdWay0;

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // Reread looks the missed request up again
  assign lookupAddr = (state == Reread) ? reqAddr : addr_i;

  assign arr.lookupEn = accept || (state == Reread);
  assign arr.lookupIndex = lookupAddr[LineOffW +: IdxW];
  assign arr.lookupWord = lookupAddr[ByteOffW +: WordSelW];
  assign arr.lookupTag = reqAddr[AddrW-1 -: TagBits];

  // refill, beats come in ascending word order
  assign arr.fillEn = (state == Refill) && rdValid_i;
  assign arr.fillDone = arr.fillEn && rdLast_i;
  assign arr.fillIndex = reqAddr[LineOffW +: IdxW];
  assign arr.fillWord = beatCnt;
  assign arr.fillData = rdData_i;

  assign cacheRdValid_o = (state == Refill);
  assign cacheAddr_o = {reqAddr[AddrW-1:LineOffW], {LineOffW{1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (state != Refill) begin
      beatCnt <= '0;
    end else if (arr.fillEn) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      Idle: begin
        if (accept) begin
          nextState = Compare;
        end
      end
      Compare: begin
        if (!arr.hit) begin
          nextState = Refill;
        end else if (!accept) begin
          nextState = Idle;
        end
      end
      Refill: begin
        if (arr.fillDone) begin
          nextState = Reread;
        end
      end
      Reread: begin
        nextState = Compare;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  // beats only after a miss was seen in Compare
  fillInRefillA: assert property (@(posedge clk) disable iff (!rst_n)
    arr.fillEn |-> state == Refill && $past(state) inside {Compare, Refill});

  // response only in the cycle after a lookup
  dataOkHitA: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |-> arr.hit && $past(arr.lookupEn));

  // memory must mark the fourth beat as last
  lastBeatA: assert property (@(posedge clk) disable iff (!rst_n)
    arr.fillDone |-> beatCnt == wordSel_t'(BeatsPerLine - 1));

endmodule

`default_nettype wire

//--- logic/cacheDataArray.sv
`timescale 1ns/1ps
`default_nettype none

module cacheDataArray #(
  parameter int NumSets = 64
) (
  input wire clk,
  cacheArrayIf.data arr
);
  import cachePkg::*;

  // behavioral stand-in for the SRAM macros with one line per set and way
  line_t lineMem [NumWays][NumSets];

  // registered read word of each way
  word_t rdWord [NumWays];

  // refill beats land in the victim way picked at Compare
  always_ff @(posedge clk) begin
    if (arr.fillEn) begin
      lineMem[arr.victimWay][arr.fillIndex][arr.fillWord] <= arr.fillData;
    end
  end

  // one-cycle read of the addressed word in both ways
  always_ff @(posedge clk) begin
    if (arr.lookupEn) begin
      for (int w = 0; w < NumWays; w++) begin
        rdWord[w] <= lineMem[w][arr.lookupIndex][arr.lookupWord];
      end
    end
  end

  assign arr.rdWay0 = rdWord[0];
  assign arr.rdWay1 = rdWord[1];

endmodule

`default_nettype wire

//--- logic/cachePkg.sv
`default_nettype none

package cachePkg;

  // address split: tag | index | word select | byte offset
  localparam int AddrW = 32;
  localparam int ByteOffW = 3;
  localparam int WordSelW = 2;
  localparam int LineOffW = ByteOffW + WordSelW;
  localparam int IndexW = 6;
  localparam int TagW = AddrW - IndexW - LineOffW;

  // one beat per word, four words per 32-byte line
  localparam int BeatsPerLine = 2 ** WordSelW;

  // way select is a single bit
  localparam int NumWays = 2;

  typedef logic [AddrW-1:0] addr_t;
  typedef logic [TagW-1:0] tag_t;
  typedef logic [IndexW-1:0] index_t;
  typedef logic [WordSelW-1:0] wordSel_t;

  // also the memory beat width
  typedef logic [63:0] word_t;

  // whole line, word 0 in the low bits
  typedef word_t [BeatsPerLine-1:0] line_t;

  typedef enum logic [1:0] {
    Idle,
    Compare,
    Refill,
    Reread
  } ctrlState_t;

endpackage

`default_nettype wire

//--- logic/cacheTagArray.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTagArray #(
  parameter int NumSets = 64
) (
  input wire clk,
  input wire rst_n,
  cacheArrayIf.tags arr
);
  import cachePkg::*;

  localparam int IdxW = $clog2(NumSets);
  localparam int TagBits = $bits(tag_t) + $bits(index_t) - IdxW;

  // per-set storage
  logic [TagBits-1:0] tagMem [NumWays][NumSets];
  logic [NumSets-1:0] validMem [NumWays];
  logic [NumSets-1:0] mruMem;

  // entry read by the last lookup
  logic [TagBits-1:0] tagQ [NumWays];
  logic [NumWays-1:0] validQ;
  logic mruQ;
  logic [IdxW-1:0] idxQ;
  logic lookupQ;

  logic [NumWays-1:0] wayHit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookupQ <= 1'b0;
      validQ <= '0;
      mruQ <= 1'b0;
    end else begin
      lookupQ <= arr.lookupEn;
      if (arr.lookupEn) begin
        for (int w = 0; w < NumWays; w++) begin
          validQ[w] <= validMem[w][arr.lookupIndex];
        end
        // a hit this cycle to the same set has not reached mruMem yet
        if (arr.hit && idxQ == arr.lookupIndex) begin
          mruQ <= arr.hitWay;
        end else begin
          mruQ <= mruMem[arr.lookupIndex];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arr.lookupEn) begin
      for (int w = 0; w < NumWays; w++) begin
        tagQ[w] <= tagMem[w][arr.lookupIndex];
      end
      idxQ <= arr.lookupIndex;
    end
  end

  // compare against the tag of the request in Compare
  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = lookupQ && validQ[w] && (tagQ[w] == arr.lookupTag);
    end
  end

  assign arr.hit = |wayHit;
  assign arr.hitWay = wayHit[1];

  // empty way first, otherwise the one not used last
  always_comb begin
    if (!validQ[0]) begin
      arr.victimWay = 1'b0;
    end else if (!validQ[1]) begin
      arr.victimWay = 1'b1;
    end else begin
      arr.victimWay = ~mruQ;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        validMem[w] <= '0;
      end
      mruMem <= '0;
    end else if (arr.fillDone) begin
      validMem[arr.victimWay][arr.fillIndex] <= 1'b1;
      mruMem[arr.fillIndex] <= arr.victimWay;
    end else if (arr.hit) begin
      mruMem[idxQ] <= arr.hitWay;
    end
  end

  always_ff @(posedge clk) begin
    if (arr.fillDone) begin
      tagMem[arr.victimWay][arr.fillIndex] <= arr.lookupTag;
    end
  end

  // refills only ever go to a way that missed
  noDoubleHitA: assert property (@(posedge clk) disable iff (!rst_n)
    lookupQ |-> !(wayHit[0] && wayHit[1]));

endmodule

`default_nettype wire

//--- logic/cacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module cacheTop #(
  parameter int NumSets = 2 ** $bits(cachePkg::index_t)
) (
  input wire clk,
  input wire rst_n,

  // pipeline side
  input wire cachePkg::addr_t addr_i,
  input wire valid_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output cachePkg::word_t rdData_o,

  // memory side
  output logic cacheRdValid_o,
  output cachePkg::addr_t cacheAddr_o,
  input wire rdValid_i,
  input wire rdLast_i,
  input wire cachePkg::word_t rdData_i
);

  cacheArrayIf #(.NumSets(NumSets)) arrIf ();

  cacheCtrl #(
    .NumSets(NumSets)
  ) i_cacheCtrl (
    .clk(clk),
    .rst_n(rst_n),
    .addr_i(addr_i),
    .valid_i(valid_i),
    .addrOk_o(addrOk_o),
    .dataOk_o(dataOk_o),
    .rdData_o(rdData_o),
    .cacheRdValid_o(cacheRdValid_o),
    .cacheAddr_o(cacheAddr_o),
    .rdValid_i(rdValid_i),
    .rdLast_i(rdLast_i),
    .rdData_i(rdData_i),
    .arr(arrIf.ctrl)
  );

  // tag, valid and LRU per set
  cacheTagArray #(
    .NumSets(NumSets)
  ) i_cacheTagArray (
    .clk(clk),
    .rst_n(rst_n),
    .arr(arrIf.tags)
  );

  cacheDataArray #(
    .NumSets(NumSets)
  ) i_cacheDataArray (
    .clk(clk),
    .arr(arrIf.data)
  );

endmodule

`default_nettype wire

//--- vlog.f
logic/cachePkg.sv
logic/cacheArrayIf.sv
logic/cacheTagArray.sv
logic/cacheDataArray.sv
logic/cacheCtrl.sv
logic/cacheTop.sv
dv/clkGen.sv
dv/memResponder.sv
dv/cacheTb.sv
